/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vic core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_vic_core \
    -Mdir obj_dir -o sim_vic
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_vic > sim.log 2>&1
status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* sim/tb_vic_core.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module tb_vic_core;

    // frame lengths in dot4x ticks, 4 ticks per pixel
    localparam int R8_RUN   = 520 * 263 * 4 + 2 * 520 * 4;
    localparam int R56A_RUN = 512 * 262 * 4 + 2 * 512 * 4;
    localparam int PAL_RUN  = 504 * 312 * 4 + 2 * 504 * 4;
    // the spare chip code runs one more pal frame
    localparam int LIMIT    = R8_RUN + R56A_RUN + 2 * PAL_RUN + 20000;

    logic                   clk_dot4x;
    logic                   rst;
    vic_chip_pkg::chip_e    chip_i;
    logic                   ce_i;
    logic                   rw_i;
    logic [`REG_ADDR_W-1:0] adi_i;
    logic [`DATA_W-1:0]     dbi_i;
    logic                   clk_phi_o;
    logic [`DATA_W-1:0]     dbo_o;
    logic                   irq_o;
    logic                   ba_o;
    logic                   aec_o;
    logic                   vic_write_db_o;
    logic                   vic_write_ab_o;
    // ticks since reset give the beam position
    int                     ticks;
    int                     edges;
    int                     seed;
    int                     cmp_line;
    logic                   den_tb;
    logic                   irq_en_tb;

    vic_core dut_i (.*);

    initial begin
        clk_dot4x = 1'b0;
        forever #2 clk_dot4x = ~clk_dot4x;
    end

    // pixels per line and lines per frame of each chip
    function automatic int x_total(vic_chip_pkg::chip_e c);
        case (c)
            vic_chip_pkg::chip_6567r8:   return 520;
            vic_chip_pkg::chip_6567r56a: return 512;
            default:                     return 504;
        endcase
    endfunction

    function automatic int y_total(vic_chip_pkg::chip_e c);
        case (c)
            vic_chip_pkg::chip_6567r8:   return 263;
            vic_chip_pkg::chip_6567r56a: return 262;
            default:                     return 312;
        endcase
    endfunction

    function automatic int line_of(int k);
        return (k / 4 / x_total(chip_i)) % y_total(chip_i);
    endfunction

    function automatic int px_of(int k);
        return (k / 4) % x_total(chip_i);
    endfunction

    // ba is low in cycles 12..54 of a badline
    function automatic logic ba_expect(int k);
        int l;
        int c;
        // before reset ba idles high
        if (k < 0) begin
            return 1'b1;
        end
        l = line_of(k);
        c = px_of(k) / 8;
        return !(den_tb && l >= `BADLINE_FIRST && l < `BADLINE_LAST && l % 8 == 3 &&
                 c >= `BA_FIRST_CYCLE && c <= `BA_LAST_CYCLE);
    endfunction

    // aec follows phi, a phi high half is lost once ba was low
    // at the last three phi high ends and still is
    function automatic logic aec_expect(int k);
        int s;
        s = k - k % 32;
        if (k % 32 < 16) begin
            return 1'b0;
        end
        return ba_expect(k) || ba_expect(s - 1) || ba_expect(s - 33) || ba_expect(s - 65);
    endfunction

    task automatic check(string name, int exp, int act);
        assert (exp == act) else begin
            $display("ERROR %s expected %0h actual %0h", name, exp, act);
            $display("test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // ------------------------------------------------
    // per tick model checks and timeout
    // ------------------------------------------------
    always @(posedge clk_dot4x) begin
        edges++;
        if (edges > LIMIT) begin
            $display("timeout, the run did not finish within %0d ticks", LIMIT);
            $display("test failed");
            $fatal(1, "timeout");
        end
        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a bound assertion on the dut ports failed");
            $display("test failed");
            $fatal(1, "assertion failure");
        end
        if (rst) begin
            ticks = 0;
        end else begin
            check("phi", (ticks / 16) % 2, clk_phi_o);
            if (!ce_i && rw_i && adi_i == 6'h12) begin
                check("raster_read", line_of(ticks) % 256, dbo_o);
            end
            if (!ce_i && rw_i && adi_i == 6'h11) begin
                check("ctrl1_read", line_of(ticks) / 256, dbo_o[7]);
            end
            // ba lags its condition by one tick, skip the cycle edge
            if (ticks % 32 != 0) begin
                check("ba", ba_expect(ticks), ba_o);
            end
            check("aec", aec_expect(ticks), aec_o);
            check("write_ab", !(aec_expect(ticks) || aec_expect(ticks - 2)), vic_write_ab_o);
            if (irq_en_tb && line_of(ticks) < cmp_line) begin
                check("irq_early", 0, irq_o);
            end
            ticks++;
        end
    end

    task automatic reset_dut(vic_chip_pkg::chip_e c);
        rst       = 1'b1;
        chip_i    = c;
        den_tb    = 1'b0;
        irq_en_tb = 1'b0;
        repeat (8) @(posedge clk_dot4x);
        #1 rst = 1'b0;
    endtask

    // held until phi high, data valid step
    task automatic write_reg(logic [`REG_ADDR_W-1:0] addr, logic [`DATA_W-1:0] data);
        ce_i  = 1'b0;
        rw_i  = 1'b0;
        adi_i = addr;
        dbi_i = data;
        do begin
            @(posedge clk_dot4x);
            #1;
        end while (((ticks - 1) % 32) != 16 + `PH_DAV);
        ce_i = 1'b1;
        rw_i = 1'b1;
    endtask

    task automatic wait_beam(int line, int px);
        do begin
            @(posedge clk_dot4x);
            #1;
        end while (!(line_of(ticks) == line && px_of(ticks) == px));
    endtask

    // reads run continuously, a wrap past the last line is included
    task automatic read_frame(vic_chip_pkg::chip_e c, logic [`REG_ADDR_W-1:0] addr);
        reset_dut(c);
        ce_i  = 1'b0;
        rw_i  = 1'b1;
        adi_i = addr;
        wait_beam(y_total(c) - 1, 0);
        wait_beam(1, 0);
        ce_i = 1'b1;
    endtask

    initial begin
        seed      = 52;
        rst       = 1'b1;
        chip_i    = vic_chip_pkg::chip_6567r8;
        ce_i      = 1'b1;
        rw_i      = 1'b1;
        adi_i     = '0;
        dbi_i     = '0;
        ticks     = 0;
        edges     = 0;
        den_tb    = 1'b0;
        irq_en_tb = 1'b0;
        cmp_line  = 249 + (($random(seed) & 32'h7fffffff) % 6);
        @(posedge clk_dot4x);
        #1;
        read_frame(vic_chip_pkg::chip_6567r8, 6'h12);
        read_frame(vic_chip_pkg::chip_6567r56a, 6'h11);
        read_frame(vic_chip_pkg::chip_unused, 6'h11);

        // pal frame with badlines and a raster irq
        reset_dut(vic_chip_pkg::chip_6569);
        write_reg(6'h11, 8'h13);
        den_tb = 1'b1;
        write_reg(6'h12, cmp_line[7:0]);
        // line 0 matched the reset compare value, drop that latch
        write_reg(6'h19, 8'h01);
        write_reg(6'h1a, 8'h01);
        irq_en_tb = 1'b1;
        ce_i  = 1'b0;
        adi_i = 6'h12;
        wait_beam(cmp_line, 100);
        check("irq_rise", 1, irq_o);
        write_reg(6'h19, 8'h01);
        ce_i  = 1'b0;
        adi_i = 6'h12;
        wait_beam(cmp_line, 400);
        check("irq_clear", 0, irq_o);
        wait_beam(cmp_line + 1, 100);
        check("irq_next_line", 0, irq_o);
        wait_beam(311, 0);
        wait_beam(1, 0);
        if (dut_i.assert_i.fail_cnt != 0) begin
            $display("a bound assertion on the dut ports failed at the end of the run");
            $display("test failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* sim/vic_core_assert.sv */
`timescale 1ns/1ps

module vic_core_assert (
    input logic clk_dot4x,
    input logic rst,
    input logic ce_i,
    input logic rw_i,
    input logic clk_phi_o,
    input logic aec_o,
    input logic ba_o,
    input logic irq_o,
    input logic vic_write_db_o
);

    // number of assertion failures so far
    int fail_cnt = 0;

    // ------------------------------------------------
    // bus direction
    // ------------------------------------------------

    // data bus turns around only while the cpu reads a selected register
    db_dir_follows_cpu: assert property (
        @(posedge clk_dot4x) vic_write_db_o == (rw_i && !ce_i)
    ) else begin
        $error("data bus direction does not match rw and ce");
        fail_cnt++;
    end

    // ------------------------------------------------
    // aec against phi and ba
    // ------------------------------------------------

    // phi low half always belongs to the vic
    aec_low_in_phi_low: assert property (
        @(posedge clk_dot4x) !clk_phi_o |-> !aec_o
    ) else begin
        $error("aec high while phi is low");
        fail_cnt++;
    end

    // cpu only loses a phi high half after ba went low
    aec_held_needs_ba: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        (clk_phi_o && !aec_o) |-> !$past(ba_o)
    ) else begin
        $error("aec held low in phi high without ba low");
        fail_cnt++;
    end

    // state right after a reset tick
    reset_outputs: assert property (
        @(posedge clk_dot4x) rst |=> (ba_o && !aec_o && !irq_o)
    ) else begin
        $error("ba, aec or irq wrong after reset");
        fail_cnt++;
    end

endmodule

bind vic_core vic_core_assert assert_i (.*);

/* sources.f */
+incdir+verilog
verilog/vic_chip_pkg.sv
verilog/vic_reg_pkg.sv
verilog/vic_phase_gen.sv
verilog/vic_raster.sv
verilog/vic_registers.sv
verilog/vic_dma_arbiter.sv
verilog/vic_core.sv
sim/vic_core_assert.sv
sim/tb_vic_core.sv

/* verilog/vic_chip_pkg.sv */
`include "vic_defs.svh"

package vic_chip_pkg;

    // chip type strap, encoding as seen on the config pins
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6567r56a = 2'd1,
        chip_6569     = 2'd2,
        // spare code, treated as pal
        chip_unused   = 2'd3
    } chip_e;

    // last pixel of a line and last line of a frame
    typedef struct packed {
        logic [`RASTER_X_W-1:0] raster_x_max;
        logic [`RASTER_Y_W-1:0] raster_y_max;
    } raster_limits_t;

    function automatic raster_limits_t limits_of(chip_e chip);
        raster_limits_t lim;
        case (chip)
            // ntsc, 65 cycles x 263 lines
            chip_6567r8: begin
                lim.raster_x_max = `RASTER_X_W'(519);
                lim.raster_y_max = `RASTER_Y_W'(262);
            end
            // old ntsc, 64 cycles x 262 lines
            chip_6567r56a: begin
                lim.raster_x_max = `RASTER_X_W'(511);
                lim.raster_y_max = `RASTER_Y_W'(261);
            end
            // pal, 63 cycles x 312 lines
            default: begin
                lim.raster_x_max = `RASTER_X_W'(503);
                lim.raster_y_max = `RASTER_Y_W'(311);
            end
        endcase
        return lim;
    endfunction

endpackage

/* verilog/vic_core.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_core (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  vic_chip_pkg::chip_e      chip_i,
    input  logic                     ce_i,
    input  logic                     rw_i,
    input  logic [`REG_ADDR_W-1:0]   adi_i,
    input  logic [`DATA_W-1:0]       dbi_i,
    output logic                     clk_phi_o,
    output logic [`DATA_W-1:0]       dbo_o,
    output logic                     irq_o,
    output logic                     ba_o,
    output logic                     aec_o,
    output logic                     vic_write_db_o,
    output logic                     vic_write_ab_o
);

    logic [`PHASE_W-1:0]    phase_idx;
    logic                   pix_tick;
    logic [`RASTER_Y_W-1:0] raster_line;
    logic [`CYCLE_W-1:0]    cycle_num;
    logic                   raster_irq_set;
    logic [`RASTER_Y_W-1:0] raster_cmp;
    vic_reg_pkg::ctrl1_u    ctrl1;

    // ------------------------------------------------
    // timing
    // ------------------------------------------------
    vic_phase_gen phase_gen_i (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .clk_phi_o   (clk_phi_o),
        .pix_tick_o  (pix_tick),
        .phase_idx_o (phase_idx)
    );

    // beam x only feeds the cycle number here
    vic_raster raster_i (
        .clk_dot4x        (clk_dot4x),
        .rst              (rst),
        .pix_tick_i       (pix_tick),
        .clk_phi_i        (clk_phi_o),
        .phase_idx_i      (phase_idx),
        .chip_i           (chip_i),
        .raster_cmp_i     (raster_cmp),
        .raster_x_o       (),
        .raster_line_o    (raster_line),
        .cycle_num_o      (cycle_num),
        .raster_irq_set_o (raster_irq_set)
    );

    // ------------------------------------------------
    // cpu side and bus arbitration
    // ------------------------------------------------
    vic_registers registers_i (
        .clk_dot4x        (clk_dot4x),
        .rst              (rst),
        .clk_phi_i        (clk_phi_o),
        .phase_idx_i      (phase_idx),
        .ce_i             (ce_i),
        .rw_i             (rw_i),
        .adi_i            (adi_i),
        .dbi_i            (dbi_i),
        .raster_line_i    (raster_line),
        .raster_irq_set_i (raster_irq_set),
        .dbo_o            (dbo_o),
        .ctrl1_o          (ctrl1),
        .raster_cmp_o     (raster_cmp),
        .irq_o            (irq_o)
    );

    vic_dma_arbiter dma_arbiter_i (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .clk_phi_i      (clk_phi_o),
        .phase_idx_i    (phase_idx),
        .raster_line_i  (raster_line),
        .cycle_num_i    (cycle_num),
        .ctrl1_i        (ctrl1),
        .ce_i           (ce_i),
        .rw_i           (rw_i),
        .ba_o           (ba_o),
        .aec_o          (aec_o),
        .vic_write_db_o (vic_write_db_o),
        .vic_write_ab_o (vic_write_ab_o)
    );

endmodule

/* verilog/vic_defs.svh */
`ifndef VIC_DEFS_SVH
`define VIC_DEFS_SVH

// ------------------------------------------------
// clocking
// ------------------------------------------------

// dot4x ticks in one half of phi
`define PHASE_STEPS 16
`define PHASE_W 4

// step where cpu write data is stable on the bus
`define PH_DAV 12
// step where line and badline state advance
`define PH_LINE 1
// step where the raster compare is evaluated
`define PH_IRQ 8

// ------------------------------------------------
// beam and bus widths
// ------------------------------------------------
`define RASTER_X_W 10
`define RASTER_Y_W 9
// one cycle covers 8 pixels
`define CYCLE_W 7
`define REG_ADDR_W 6
`define DATA_W 8

// ------------------------------------------------
// dma windows
// ------------------------------------------------

// badlines only happen on lines first..last-1
`define BADLINE_FIRST 48
`define BADLINE_LAST 248
// cycles where ba is held low on a badline
`define BA_FIRST_CYCLE 12
`define BA_LAST_CYCLE 54
// phi cycles between ba falling and aec being held
`define AEC_CASCADE 3

`endif

/* verilog/vic_dma_arbiter.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_dma_arbiter (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     clk_phi_i,
    input  logic [`PHASE_W-1:0]      phase_idx_i,
    input  logic [`RASTER_Y_W-1:0]   raster_line_i,
    input  logic [`CYCLE_W-1:0]      cycle_num_i,
    input  vic_reg_pkg::ctrl1_u      ctrl1_i,
    input  logic                     ce_i,
    input  logic                     rw_i,
    output logic                     ba_o,
    output logic                     aec_o,
    output logic                     vic_write_db_o,
    output logic                     vic_write_ab_o
);

    logic                    line_step;
    logic                    last_step;
    logic                    in_window;
    logic                    allow_bad_lines;
    logic                    allow_next;
    logic                    badline;
    logic                    ba_cond;
    // ba sampled at the end of the last few phi high halves
    logic [`AEC_CASCADE-1:0] ba_hist;
    logic [1:0]              aec_dly;

    assign line_step = !clk_phi_i && (phase_idx_i == `PHASE_W'(`PH_LINE));
    assign last_step = (phase_idx_i == `PHASE_W'(`PHASE_STEPS - 1));
    assign in_window = (raster_line_i >= `RASTER_Y_W'(`BADLINE_FIRST)) &&
                       (raster_line_i < `RASTER_Y_W'(`BADLINE_LAST));

    // ------------------------------------------------
    // badline detection
    // ------------------------------------------------
    always_comb begin
        allow_next = allow_bad_lines;
        // den anywhere on line 48 arms badlines for the frame
        if (ctrl1_i.f.den && raster_line_i == `RASTER_Y_W'(`BADLINE_FIRST)) begin
            allow_next = 1'b1;
        end
        if (raster_line_i == `RASTER_Y_W'(`BADLINE_LAST)) begin
            allow_next = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow_bad_lines <= 1'b0;
            badline         <= 1'b0;
        end else if (line_step) begin
            allow_bad_lines <= allow_next;
            badline <= in_window && allow_next &&
                       (raster_line_i[2:0] == ctrl1_i.f.yscroll);
        end
    end

    // c-access window, ba low is active
    assign ba_cond = !(badline &&
                       cycle_num_i >= `CYCLE_W'(`BA_FIRST_CYCLE) &&
                       cycle_num_i <= `CYCLE_W'(`BA_LAST_CYCLE));

    // ------------------------------------------------
    // ba and aec cascade
    // ------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o    <= 1'b1;
            ba_hist <= '1;
            aec_o   <= 1'b0;
            aec_dly <= '0;
        end else begin
            ba_o <= ba_cond;
            if (clk_phi_i && last_step) begin
                ba_hist <= {ba_hist[`AEC_CASCADE-2:0], ba_o};
            end
            // use next phi so aec lines up with clk_phi
            // cpu keeps its half until ba has been low for the full cascade
            aec_o   <= (clk_phi_i ^ last_step) & (ba_o | (|ba_hist));
            aec_dly <= {aec_dly[0], aec_o};
        end
    end

    // cpu reading from us
    assign vic_write_db_o = rw_i & ~ce_i;

    // drive address two ticks after aec falls, release as soon as it rises
    assign vic_write_ab_o = ~(aec_o | aec_dly[1]);

endmodule

/* verilog/vic_phase_gen.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_phase_gen (
    input  logic                clk_dot4x,
    input  logic                rst,
    output logic                clk_phi_o,
    output logic                pix_tick_o,
    output logic [`PHASE_W-1:0] phase_idx_o
);

    logic last_step;

    // phase index runs 0..15 within each half of phi
    assign last_step = (phase_idx_o == `PHASE_W'(`PHASE_STEPS - 1));

    // ------------------------------------------------
    // phase counter and phi
    // ------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // start in the low half, vic owns the bus first
            clk_phi_o   <= 1'b0;
            phase_idx_o <= '0;
        end else begin
            // counter wraps by itself at the end of a half
            phase_idx_o <= phase_idx_o + 1'b1;
            if (last_step) begin
                clk_phi_o <= ~clk_phi_o;
            end
        end
    end

    // one pixel lasts 4 dot4x ticks
    // fires on the last tick of each pixel so 8 pixels fit one phi period
    assign pix_tick_o = (phase_idx_o[1:0] == 2'b11);

endmodule

/* verilog/vic_raster.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_raster (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     pix_tick_i,
    input  logic                     clk_phi_i,
    input  logic [`PHASE_W-1:0]      phase_idx_i,
    input  vic_chip_pkg::chip_e      chip_i,
    input  logic [`RASTER_Y_W-1:0]   raster_cmp_i,
    output logic [`RASTER_X_W-1:0]   raster_x_o,
    output logic [`RASTER_Y_W-1:0]   raster_line_o,
    output logic [`CYCLE_W-1:0]      cycle_num_o,
    output logic                     raster_irq_set_o
);

    vic_chip_pkg::raster_limits_t lim;
    logic                         end_of_line;
    logic                         line_match;
    // compare already fired on this line
    logic                         irq_triggered;

    assign lim = vic_chip_pkg::limits_of(chip_i);

    // >= keeps the counter sane if the chip strap changes mid line
    assign end_of_line = (raster_x_o >= lim.raster_x_max);

    // ------------------------------------------------
    // beam position
    // ------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x_o    <= '0;
            raster_line_o <= '0;
        end else if (pix_tick_i) begin
            if (end_of_line) begin
                raster_x_o <= '0;
                // new line starts with the next phi low half
                if (raster_line_o >= lim.raster_y_max) begin
                    raster_line_o <= '0;
                end else begin
                    raster_line_o <= raster_line_o + 1'b1;
                end
            end else begin
                raster_x_o <= raster_x_o + 1'b1;
            end
        end
    end

    // 8 pixels per cycle
    assign cycle_num_o = raster_x_o[`RASTER_X_W-1:3];

    // ------------------------------------------------
    // raster compare
    // ------------------------------------------------
    assign line_match = (raster_line_o == raster_cmp_i);

    // single tick strobe, only once per matching line
    assign raster_irq_set_o = line_match && !clk_phi_i && !irq_triggered &&
                              (phase_idx_i == `PHASE_W'(`PH_IRQ));

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq_triggered <= 1'b0;
        end else if (!line_match) begin
            // rearm once line or compare value moves on
            irq_triggered <= 1'b0;
        end else if (raster_irq_set_o) begin
            irq_triggered <= 1'b1;
        end
    end

endmodule

/* verilog/vic_reg_pkg.sv */
`include "vic_defs.svh"

package vic_reg_pkg;

    // ------------------------------------------------
    // register map, offsets within the $d0xx block
    // ------------------------------------------------
    typedef enum logic [`REG_ADDR_W-1:0] {
        reg_ctrl1      = 6'h11,
        reg_raster     = 6'h12,
        reg_irq_latch  = 6'h19,
        reg_irq_enable = 6'h1a
    } reg_addr_e;

    // control register 1, msb first
    typedef struct packed {
        // bit 8 of the raster compare line
        logic       raster8;
        // extended colour mode
        logic       ecm;
        // bitmap mode
        logic       bmm;
        // display enable, sampled on line 48
        logic       den;
        // 24/25 row select
        logic       rsel;
        // fine vertical scroll, selects the badline row
        logic [2:0] yscroll;
    } ctrl1_fields_t;

    // raw byte for bus access, fields for decode
    typedef union packed {
        logic [`DATA_W-1:0] raw;
        ctrl1_fields_t      f;
    } ctrl1_u;

    // unimplemented bits of $19 and $1a read as ones
    parameter logic [`DATA_W-1:0] IRQ_UNUSED_BITS = 8'hfe;

endpackage

/* verilog/vic_registers.sv */
`timescale 1ns/1ps

`include "vic_defs.svh"

module vic_registers (
    input  logic                     clk_dot4x,
    input  logic                     rst,
    input  logic                     clk_phi_i,
    input  logic [`PHASE_W-1:0]      phase_idx_i,
    input  logic                     ce_i,
    input  logic                     rw_i,
    input  logic [`REG_ADDR_W-1:0]   adi_i,
    input  logic [`DATA_W-1:0]       dbi_i,
    input  logic [`RASTER_Y_W-1:0]   raster_line_i,
    input  logic                     raster_irq_set_i,
    output logic [`DATA_W-1:0]       dbo_o,
    output vic_reg_pkg::ctrl1_u      ctrl1_o,
    output logic [`RASTER_Y_W-1:0]   raster_cmp_o,
    output logic                     irq_o
);

    logic                 wr_stb;
    logic [`DATA_W-1:0]   raster_lo_q;
    logic                 irq_latch_q;
    logic                 irq_enable_q;
    vic_reg_pkg::ctrl1_u  ctrl1_q;
    vic_reg_pkg::reg_addr_e addr;

    assign addr = vic_reg_pkg::reg_addr_e'(adi_i);

    // cpu write, data sampled once in the phi high half
    assign wr_stb = !ce_i && !rw_i && clk_phi_i &&
                    (phase_idx_i == `PHASE_W'(`PH_DAV));

    // ------------------------------------------------
    // register writes and irq latch
    // ------------------------------------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ctrl1_q.raw  <= '0;
            raster_lo_q  <= '0;
            irq_latch_q  <= 1'b0;
            irq_enable_q <= 1'b0;
        end else begin
            // compare match latches regardless of enable
            if (raster_irq_set_i) begin
                irq_latch_q <= 1'b1;
            end
            if (wr_stb) begin
                case (addr)
                    vic_reg_pkg::reg_ctrl1:  ctrl1_q.raw <= dbi_i;
                    vic_reg_pkg::reg_raster: raster_lo_q <= dbi_i;
                    // write one to acknowledge
                    vic_reg_pkg::reg_irq_latch: begin
                        if (dbi_i[0]) begin
                            irq_latch_q <= 1'b0;
                        end
                    end
                    vic_reg_pkg::reg_irq_enable: irq_enable_q <= dbi_i[0];
                    default: ;
                endcase
            end
        end
    end

    assign ctrl1_o = ctrl1_q;

    // bit 8 of the compare line lives in $11
    assign raster_cmp_o = {ctrl1_q.f.raster8, raster_lo_q};

    assign irq_o = irq_latch_q & irq_enable_q;

    // ------------------------------------------------
    // readback
    // ------------------------------------------------
    always_comb begin
        case (addr)
            // bit 7 reads the beam, not the stored compare bit
            vic_reg_pkg::reg_ctrl1:  dbo_o = {raster_line_i[8], ctrl1_q.raw[6:0]};
            vic_reg_pkg::reg_raster: dbo_o = raster_line_i[7:0];
            vic_reg_pkg::reg_irq_latch: begin
                dbo_o = {irq_o, vic_reg_pkg::IRQ_UNUSED_BITS[6:1], irq_latch_q};
            end
            vic_reg_pkg::reg_irq_enable: begin
                dbo_o = vic_reg_pkg::IRQ_UNUSED_BITS | {7'b0, irq_enable_q};
            end
            // unmapped registers float high
            default: dbo_o = '1;
        endcase
    end

endmodule
